// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // word geometry
    localparam int word_width     = 32;
    localparam int bytes_per_word = 4;
    localparam int lane_width     = $clog2(bytes_per_word);

    // address widths, word address plus lane offset
    localparam int mem_addr_width  = 10;
    localparam int byte_addr_width = mem_addr_width + lane_width;

    typedef logic [word_width-1:0]      word_t;
    typedef logic [mem_addr_width-1:0]  word_addr_t;
    typedef logic [byte_addr_width-1:0] byte_addr_t;
    typedef logic [bytes_per_word-1:0]  byte_en_t;

    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

    // returned by the RAM when a read hits a same-cycle write
    localparam word_t collision_marker = word_t'(32'hdeadbeef);

    // read data in the cycle after reset
    localparam word_t reset_read_value = '0;

    // halfword needs bit 0 clear and word needs both low bits clear
    function automatic logic is_misaligned(input byte_addr_t addr, input access_size_t size);
        logic bad;
        case (size)
            size_byte: bad = 1'b0;
            size_half: bad = addr[0];
            size_word: bad = |addr[lane_width-1:0];
            // unused encoding is never a legal access
            default:   bad = 1'b1;
        endcase
        return bad;
    endfunction

endpackage

`default_nettype wire

// ==== src/dual_port_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_port_bram (
    input  logic                clk,
    input  logic                reset_reg,

    // port 1, write only
    input  mem_pkg::byte_en_t   wr_byte_en,
    input  mem_pkg::word_addr_t wr_addr,
    input  mem_pkg::word_t      wr_data,

    // port 2, read only
    input  mem_pkg::word_addr_t rd_addr,
    output mem_pkg::word_t      rd_data,
    output logic                rd_collision
);

    import mem_pkg::*;

    // storage, one byte per lane
    logic [bytes_per_word-1:0][7:0] mem [2**mem_addr_width];

    // registered read address
    word_addr_t addr_q;

    // delayed reset selects the reset value on the read port
    logic reset_q;

    // same-word write seen when the read address was taken
    logic collision_hit;
    logic collision_q;

    assign collision_hit = (wr_addr == rd_addr) && (|wr_byte_en);

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < bytes_per_word; i++) begin
            if (wr_byte_en[i]) begin
                mem[wr_addr][i] <= wr_data[8*i +: 8];
            end
        end
    end

    // read address stage
    always_ff @(posedge clk) begin
        addr_q <= rd_addr;
    end

    always_ff @(posedge clk) begin
        reset_q <= reset_reg;
    end

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            collision_q <= 1'b0;
        end else begin
            collision_q <= collision_hit;
        end
    end

    // the array is looked up after the write edge, so a write at an
    // earlier edge is always visible here (write-first)
    always_comb begin
        if (reset_q) begin
            rd_data = reset_read_value;
        end else if (collision_q) begin
            rd_data = collision_marker;
        end else begin
            rd_data = mem[addr_q];
        end
    end

    assign rd_collision = collision_q;

endmodule

`default_nettype wire

// ==== src/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  logic                  clk,
    input  logic                  reset_reg,

    // store request
    input  logic                  st_valid,
    input  mem_pkg::byte_addr_t   st_addr,
    input  mem_pkg::access_size_t st_size,
    input  mem_pkg::word_t        st_data,
    output logic                  st_misaligned,

    // RAM write port
    output mem_pkg::byte_en_t     wr_byte_en,
    output mem_pkg::word_addr_t   wr_addr,
    output mem_pkg::word_t        wr_data
);

    import mem_pkg::*;

    logic [lane_width-1:0] lane;
    logic                  bad_align;
    byte_en_t              lane_en;

    assign lane      = st_addr[lane_width-1:0];
    assign bad_align = is_misaligned(st_addr, st_size);
    assign wr_addr   = st_addr[byte_addr_width-1:lane_width];

    // replicate narrow data into every lane and let the enables pick
    always_comb begin
        case (st_size)
            size_byte: begin
                lane_en = byte_en_t'(1) << lane;
                wr_data = {bytes_per_word{st_data[7:0]}};
            end
            size_half: begin
                lane_en = byte_en_t'(3) << lane;
                wr_data = {(bytes_per_word / 2){st_data[15:0]}};
            end
            default: begin
                lane_en = '1;
                wr_data = st_data;
            end
        endcase
    end

    // nonzero enables are the write strobe
    assign wr_byte_en = (st_valid && !bad_align) ? lane_en : '0;

    // misalignment reported one cycle after the request
    always_ff @(posedge clk) begin
        if (reset_reg) begin
            st_misaligned <= 1'b0;
        end else begin
            st_misaligned <= st_valid && bad_align;
        end
    end

endmodule

`default_nettype wire

// ==== src/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  logic                  clk,
    input  logic                  reset_reg,

    // load request
    input  logic                  ld_valid,
    input  mem_pkg::byte_addr_t   ld_addr,
    input  mem_pkg::access_size_t ld_size,
    input  logic                  ld_signed,

    // load result
    output logic                  ld_done,
    output mem_pkg::word_t        ld_data,
    output logic                  ld_collision,
    output logic                  ld_misaligned,

    // RAM read port
    output mem_pkg::word_addr_t   rd_addr,
    input  mem_pkg::word_t        rd_data,
    input  logic                  rd_collision
);

    import mem_pkg::*;

    // context of the request whose read is in the RAM
    logic                  valid_q;
    logic                  misaligned_q;
    logic [lane_width-1:0] lane_q;
    access_size_t          size_q;
    logic                  signed_q;

    word_t lane_word;
    word_t result;
    logic  drop;

    // RAM reads every cycle, address straight from the request
    assign rd_addr = ld_addr[byte_addr_width-1:lane_width];

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            valid_q      <= 1'b0;
            misaligned_q <= 1'b0;
        end else begin
            valid_q      <= ld_valid;
            misaligned_q <= ld_valid && is_misaligned(ld_addr, ld_size);
        end
    end

    always_ff @(posedge clk) begin
        lane_q   <= ld_addr[lane_width-1:0];
        size_q   <= ld_size;
        signed_q <= ld_signed;
    end

    // addressed lane moved down to bit 0
    assign lane_word = rd_data >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            size_byte: result = {{(word_width - 8){signed_q & lane_word[7]}}, lane_word[7:0]};
            size_half: result = {{(word_width - 16){signed_q & lane_word[15]}}, lane_word[15:0]};
            default:   result = rd_data;
        endcase
    end

    // marker and misaligned reads never reach ld_data
    assign drop = misaligned_q || rd_collision;

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            ld_done       <= 1'b0;
            ld_collision  <= 1'b0;
            ld_misaligned <= 1'b0;
            ld_data       <= '0;
        end else begin
            ld_done       <= valid_q;
            ld_collision  <= valid_q && !misaligned_q && rd_collision;
            ld_misaligned <= misaligned_q;
            ld_data       <= (valid_q && !drop) ? result : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/data_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem_top (
    input  logic                  clk,
    input  logic                  reset_reg,

    // store side
    input  logic                  st_valid,
    input  mem_pkg::byte_addr_t   st_addr,
    input  mem_pkg::access_size_t st_size,
    input  mem_pkg::word_t        st_data,
    output logic                  st_misaligned,

    // load side
    input  logic                  ld_valid,
    input  mem_pkg::byte_addr_t   ld_addr,
    input  mem_pkg::access_size_t ld_size,
    input  logic                  ld_signed,
    output logic                  ld_done,
    output mem_pkg::word_t        ld_data,
    output logic                  ld_collision,
    output logic                  ld_misaligned
);

    import mem_pkg::*;

    // store side to RAM port 1
    byte_en_t   wr_byte_en;
    word_addr_t wr_addr;
    word_t      wr_data;

    // RAM port 2 and load side
    word_addr_t rd_addr;
    word_t      rd_data;
    logic       rd_collision;

    store_align i_store_align (
        .clk           (clk),
        .reset_reg     (reset_reg),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_size       (st_size),
        .st_data       (st_data),
        .st_misaligned (st_misaligned),
        .wr_byte_en    (wr_byte_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    dual_port_bram i_dual_port_bram (
        .clk          (clk),
        .reset_reg    (reset_reg),
        .wr_byte_en   (wr_byte_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_collision (rd_collision)
    );

    load_extract i_load_extract (
        .clk           (clk),
        .reset_reg     (reset_reg),
        .ld_valid      (ld_valid),
        .ld_addr       (ld_addr),
        .ld_size       (ld_size),
        .ld_signed     (ld_signed),
        .ld_done       (ld_done),
        .ld_data       (ld_data),
        .ld_collision  (ld_collision),
        .ld_misaligned (ld_misaligned),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_collision  (rd_collision)
    );

endmodule

`default_nettype wire

// ==== verif/data_mem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem_assertions (
    input logic           clk,
    input logic           reset_reg,
    input logic           ld_valid,
    input logic           ld_done,
    input mem_pkg::word_t ld_data,
    input logic           ld_collision,
    input logic           ld_misaligned,
    input logic           st_misaligned
);

    // request sampled at one edge, result registered at the next
    done_follows_valid: assert property (
        @(posedge clk) disable iff (reset_reg) ld_valid |-> ##2 ld_done
    ) else $error("ld_done did not follow ld_valid");

    no_spurious_done: assert property (
        @(posedge clk) disable iff (reset_reg) ld_done |-> $past(ld_valid, 2)
    ) else $error("ld_done without a matching ld_valid");

    // collision carries zero data
    collision_zero_data: assert property (
        @(posedge clk) disable iff (reset_reg) ld_collision |-> (ld_done && ld_data == '0)
    ) else $error("ld_collision with ld_done low or nonzero data");

    outputs_low_after_reset: assert property (
        @(posedge clk) $past(reset_reg) |->
            (!ld_done && !ld_collision && !ld_misaligned && !st_misaligned && ld_data == '0)
    ) else $error("outputs not cleared after reset");

endmodule

bind data_mem_top data_mem_assertions i_data_mem_assertions (
    .clk           (clk),
    .reset_reg     (reset_reg),
    .ld_valid      (ld_valid),
    .ld_done       (ld_done),
    .ld_data       (ld_data),
    .ld_collision  (ld_collision),
    .ld_misaligned (ld_misaligned),
    .st_misaligned (st_misaligned)
);

`default_nettype wire

// ==== verif/data_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem_tb;

    import mem_pkg::*;

    localparam int region_bytes  = 256;
    localparam int init_words    = region_bytes / bytes_per_word;
    localparam int table_len     = 17;
    localparam int random_ops    = 300;
    localparam int load_timeout  = 4;
    localparam int drain_timeout = 20;

    typedef struct packed {
        logic         st_v;
        byte_addr_t   st_a;
        access_size_t st_s;
        word_t        st_d;
        logic         ld_v;
        byte_addr_t   ld_a;
        access_size_t ld_s;
        logic         ld_sg;
    } row_t;

    logic         clk;
    logic         reset_reg;
    logic         st_valid;
    byte_addr_t   st_addr;
    access_size_t st_size;
    word_t        st_data;
    logic         st_misaligned;
    logic         ld_valid;
    byte_addr_t   ld_addr;
    access_size_t ld_size;
    logic         ld_signed;
    logic         ld_done;
    word_t        ld_data;
    logic         ld_collision;
    logic         ld_misaligned;

    // reference memory covering the exercised region
    logic [7:0] ref_mem [region_bytes];

    // expected load results in issue order
    word_t exp_data_q [$];
    logic  exp_coll_q [$];
    logic  exp_mis_q  [$];
    int    exp_cycle_q [$];

    row_t  table_rows [table_len];
    int    cycle;
    logic  st_exp_d;
    logic  st_exp_q;
    int    seed;

    data_mem_top i_data_mem_top (
        .clk           (clk),
        .reset_reg     (reset_reg),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_size       (st_size),
        .st_data       (st_data),
        .st_misaligned (st_misaligned),
        .ld_valid      (ld_valid),
        .ld_addr       (ld_addr),
        .ld_size       (ld_size),
        .ld_signed     (ld_signed),
        .ld_done       (ld_done),
        .ld_data       (ld_data),
        .ld_collision  (ld_collision),
        .ld_misaligned (ld_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run("value check failed");
        end
    endtask

    function automatic logic bad_alignment(input byte_addr_t a, input access_size_t s);
        logic bad;
        case (s)
            size_byte: bad = 1'b0;
            size_half: bad = a[0];
            default:   bad = a[1] | a[0];
        endcase
        return bad;
    endfunction

    task automatic ref_store(input byte_addr_t a, input access_size_t s, input word_t d);
        int idx;
        idx = int'(a[7:0]);
        if (s == size_byte) begin
            ref_mem[idx] = d[7:0];
        end else if (s == size_half) begin
            ref_mem[idx]     = d[7:0];
            ref_mem[idx + 1] = d[15:8];
        end else begin
            for (int i = 0; i < 4; i++) begin
                ref_mem[idx + i] = d[8*i +: 8];
            end
        end
    endtask

    function automatic word_t ref_load(input byte_addr_t a, input access_size_t s, input logic sg);
        int          idx;
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        idx = int'(a[7:0]);
        if (s == size_byte) begin
            b = ref_mem[idx];
            w = {{24{sg & b[7]}}, b};
        end else if (s == size_half) begin
            h = {ref_mem[idx + 1], ref_mem[idx]};
            w = {{16{sg & h[15]}}, h};
        end else begin
            w = {ref_mem[idx + 3], ref_mem[idx + 2], ref_mem[idx + 1], ref_mem[idx]};
        end
        return w;
    endfunction

    function automatic row_t make_row(
        input logic st_v, input byte_addr_t st_a, input access_size_t st_s, input word_t st_d,
        input logic ld_v, input byte_addr_t ld_a, input access_size_t ld_s, input logic ld_sg
    );
        row_t r;
        r = '{st_v, st_a, st_s, st_d, ld_v, ld_a, ld_s, ld_sg};
        return r;
    endfunction

    task automatic expect_load(input word_t d, input logic c, input logic m);
        exp_data_q.push_back(d);
        exp_coll_q.push_back(c);
        exp_mis_q.push_back(m);
        exp_cycle_q.push_back(cycle);
    endtask

    // drive one request pair and record what the model predicts for it
    task automatic apply_op(input row_t r);
        logic st_ok;
        @(posedge clk);
        #1;
        st_valid  = r.st_v;
        st_addr   = r.st_a;
        st_size   = r.st_s;
        st_data   = r.st_d;
        ld_valid  = r.ld_v;
        ld_addr   = r.ld_a;
        ld_size   = r.ld_s;
        ld_signed = r.ld_sg;
        st_ok     = r.st_v && !bad_alignment(r.st_a, r.st_s);
        st_exp_d  = r.st_v && bad_alignment(r.st_a, r.st_s);
        if (st_ok) begin
            ref_store(r.st_a, r.st_s, r.st_d);
        end
        if (r.ld_v) begin
            if (bad_alignment(r.ld_a, r.ld_s)) begin
                expect_load('0, 1'b0, 1'b1);
            end else if (st_ok && (r.st_a[11:2] == r.ld_a[11:2])) begin
                expect_load('0, 1'b1, 1'b0);
            end else begin
                expect_load(ref_load(r.ld_a, r.ld_s, r.ld_sg), 1'b0, 1'b0);
            end
        end
    endtask

    task automatic build_table;
        table_rows[0]  = make_row(1, 12'h010, size_word, 32'h11223344, 0, 12'h000, size_word, 0);
        table_rows[1]  = make_row(1, 12'h014, size_word, 32'h8899aabb, 1, 12'h010, size_word, 0);
        table_rows[2]  = make_row(1, 12'h018, size_word, 32'hcafef00d, 1, 12'h014, size_word, 0);
        table_rows[3]  = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h018, size_word, 0);
        table_rows[4]  = make_row(1, 12'h011, size_byte, 32'h000000e5, 1, 12'h00c, size_word, 0);
        table_rows[5]  = make_row(1, 12'h016, size_half, 32'h00007f80, 1, 12'h010, size_word, 0);
        table_rows[6]  = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h014, size_word, 0);
        table_rows[7]  = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h011, size_byte, 1);
        table_rows[8]  = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h011, size_byte, 0);
        table_rows[9]  = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h014, size_half, 1);
        table_rows[10] = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h014, size_half, 0);
        table_rows[11] = make_row(1, 12'h021, size_word, 32'h01234567, 1, 12'h020, size_word, 0);
        table_rows[12] = make_row(1, 12'h023, size_half, 32'h0000beef, 1, 12'h023, size_half, 1);
        table_rows[13] = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h022, size_word, 0);
        table_rows[14] = make_row(1, 12'h030, size_word, 32'h5555aaaa, 1, 12'h030, size_word, 0);
        table_rows[15] = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h030, size_word, 0);
        table_rows[16] = make_row(0, 12'h000, size_word, 32'h0, 1, 12'h020, size_word, 0);
    endtask

    function automatic byte_addr_t aligned_addr(input logic [7:0] raw, input access_size_t s);
        byte_addr_t a;
        a = {4'h0, raw};
        if (s == size_half) begin
            a[0] = 1'b0;
        end else if (s == size_word) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    task automatic random_op;
        logic [31:0]  r_ctl;
        logic [31:0]  r_data;
        access_size_t ss;
        access_size_t ls;
        row_t         r;
        r_ctl  = $random(seed);
        r_data = $random(seed);
        ss = access_size_t'(2'(r_ctl[3:0] % 3));
        ls = access_size_t'(2'(r_ctl[7:4] % 3));
        r  = make_row(r_ctl[8], aligned_addr(r_ctl[23:16], ss), ss, r_data,
                      r_ctl[9], aligned_addr(r_ctl[31:24], ls), ls, r_ctl[10]);
        apply_op(r);
    endtask

    always @(posedge clk) begin
        cycle    = cycle + 1;
        st_exp_q = st_exp_d;
    end

    // outputs are compared mid-cycle where they are stable
    always @(negedge clk) begin
        if (!reset_reg) begin
            check("st_misaligned", 32'(st_misaligned), 32'(st_exp_q));
            if (ld_done) begin
                if (exp_data_q.size() == 0) begin
                    stop_run("ld_done was raised with no load outstanding");
                end
                check("ld_data", ld_data, exp_data_q.pop_front());
                check("ld_collision", 32'(ld_collision), 32'(exp_coll_q.pop_front()));
                check("ld_misaligned", 32'(ld_misaligned), 32'(exp_mis_q.pop_front()));
                void'(exp_cycle_q.pop_front());
            end else if (exp_cycle_q.size() > 0 && cycle - exp_cycle_q[0] > load_timeout) begin
                stop_run("timed out waiting for ld_done of an issued load");
            end
        end
    end

    initial begin
        int waited;
        reset_reg = 1'b1;
        st_valid  = 1'b0;
        st_addr   = '0;
        st_size   = size_word;
        st_data   = '0;
        ld_valid  = 1'b0;
        ld_addr   = '0;
        ld_size   = size_word;
        ld_signed = 1'b0;
        cycle     = 0;
        st_exp_d  = 1'b0;
        st_exp_q  = 1'b0;
        seed      = 32'h34b6;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        reset_reg = 1'b0;

        // fill the exercised region so every load has defined data
        for (int i = 0; i < init_words; i++) begin
            apply_op(make_row(1, byte_addr_t'(i * 4), size_word,
                              word_t'(i * 32'h9e3779b1 + 32'h12345678),
                              0, '0, size_word, 0));
        end
        for (int i = 0; i < table_len; i++) begin
            apply_op(table_rows[i]);
        end
        for (int i = 0; i < random_ops; i++) begin
            random_op();
        end
        apply_op(make_row(0, '0, size_word, '0, 0, '0, size_word, 0));

        waited = 0;
        while (exp_data_q.size() > 0 && waited < drain_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data_q.size() > 0) begin
            stop_run("timed out waiting for the last loads to complete");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/mem_pkg.sv
src/dual_port_bram.sv
src/store_align.sv
src/load_extract.sv
src/data_mem_top.sv
verif/data_mem_assertions.sv
verif/data_mem_tb.sv

// ==== Makefile ====
# Verilator build and run of the data memory testbench

VERILATOR ?= verilator
TOP       ?= data_mem_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv) $(wildcard verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
